// File: filelist.f
logic/fc_layer_pkg.sv
logic/fc_mem_pkg.sv
logic/fc_weight_ram.sv
logic/fc_bram_sequencer.sv
logic/fc_operand_regs.sv
logic/fc_mac_engine.sv
logic/fc_top.sv
testbench/tb_fc_top.sv

// File: testbench/tb_fc_top.sv
// Testbench for the fully connected layer with directed and random frames against a reference model
`timescale 1ns/10ps

module tb_fc_top;
    import fc_layer_pkg::*;
    import fc_mem_pkg::*;

    // Eleven frame words with word k at bit 32k
    typedef logic [frame_words*32-1:0] frame_t;

    // Frames sent over the whole run
    localparam int n_frames    = 24;
    // Budget of 300 cycles per frame
    localparam int cycle_limit = n_frames * 300;

    logic         clk;
    logic         rstn;
    logic         r_valid;
    word_t        in_data;
    logic         t_valid;
    result_word_t out_data;

    result_word_t expect_q [$];
    result_word_t last_result;
    logic [31:0]  rng_state;
    int           err_cnt;
    int           check_cnt;
    int           pulse_cnt;
    int           frames_sent;
    int           cycle_cnt;

    fc_top i_fc_top (
        .clk      (clk),
        .rstn     (rstn),
        .r_valid  (r_valid),
        .in_data  (in_data),
        .t_valid  (t_valid),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////

    // LCG step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Dot product plus bias at bit 8, then floor shift by 8 and clamp to int8
    function automatic result_word_t ref_layer(input frame_t f);
        int           acc;
        int           q;
        result_word_t res;
        res = '0;
        for (int j = 0; j < 4; j++) begin
            acc = 0;
            for (int i = 0; i < 8; i++) begin
                // Row j starts at frame word 2+2j
                acc += int'($signed(f[8*i +: 8])) * int'($signed(f[64*j + 64 + 8*i +: 8]));
            end
            acc += int'($signed(f[320 + 8*j +: 8])) * 256;
            q = acc >>> 8;
            if (q > 127) begin
                q = 127;
            end
            if (q < -128) begin
                q = -128;
            end
            res[8*j +: 8] = 8'(q);
        end
        return res;
    endfunction

    // One word per r_valid with an optional random gap before each word
    task automatic send_frame(input frame_t f, input int max_gap);
        int gap;
        expect_q.push_back(ref_layer(f));
        frames_sent++;
        for (int k = 0; k < frame_words; k++) begin
            gap = (max_gap > 0) ? int'((next_rand() >> 16) % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                r_valid <= 1'b0;
            end
            @(posedge clk);
            r_valid <= 1'b1;
            in_data <= f[32*k +: 32];
        end
        @(posedge clk);
        r_valid <= 1'b0;
    endtask

    task automatic wait_results();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_value(input result_word_t got, input result_word_t exp,
                               input string what);
        check_cnt++;
        assert (got === exp)
        else begin
            $display("ERROR at %0t: %s 0x%h, expected 0x%h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic test_done(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // Result compare and timeout
    ////////////////////////////////////////

    // Each result pulse is checked against the oldest expected word
    always @(negedge clk) begin
        if (rstn && t_valid) begin
            pulse_cnt++;
            last_result = out_data;
            if (expect_q.size() == 0) begin
                $display("Unexpected t_valid pulse at %0t with no frame outstanding", $time);
                err_cnt++;
            end else begin
                check_value(out_data, expect_q.pop_front(), "out_data");
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        frame_t       frame;
        result_word_t held;
        int           errs_before;
        logic         result_seen;

        rstn        = 1'b0;
        r_valid     = 1'b0;
        in_data     = '0;
        rng_state   = 32'h62455300;
        err_cnt     = 0;
        check_cnt   = 0;
        pulse_cnt   = 0;
        frames_sent = 0;
        cycle_cnt   = 0;
        last_result = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // Idle outputs after reset
        errs_before = err_cnt;
        repeat (4) begin
            @(negedge clk);
            check_value(result_word_t'(t_valid), '0, "t_valid");
            check_value(out_data, '0, "out_data after reset");
        end
        test_done("Test 1 reset state", errs_before);

        // Small values with one rounding down and two negative results
        errs_before = err_cnt;
        frame = {32'h02FD0001, 32'h00000000, 32'h00004040, 32'h01010101,
                 32'h01010101, 32'h00000020, 32'h00000000, 32'h00000000,
                 32'h00000020, 32'hD8E2ECF6, 32'h281E140A};
        send_frame(frame, 0);
        wait_results();
        check_value(last_result, 32'h09FDFE02, "small frame result");
        test_done("Test 2 small values", errs_before);

        // Large products clamp high on output 0 and low on output 1
        errs_before = err_cnt;
        frame = {32'h00000000, 32'h01010101, 32'h01010101, 32'h00000000,
                 32'h00000000, 32'h80808080, 32'h80808080, 32'h7F7F7F7F,
                 32'h7F7F7F7F, 32'h7F7F7F7F, 32'h7F7F7F7F};
        send_frame(frame, 0);
        wait_results();
        check_value(last_result, 32'h0300807F, "saturation frame result");
        test_done("Test 3 saturation", errs_before);

        // Random frames with gaps of up to 3 cycles between words
        errs_before = err_cnt;
        for (int n = 0; n < 20; n++) begin
            for (int k = 0; k < frame_words; k++) begin
                frame[32*k +: 32] = next_rand();
            end
            send_frame(frame, 3);
            wait_results();
        end
        check_value(result_word_t'(pulse_cnt), result_word_t'(frames_sent), "t_valid count");
        test_done("Test 4 random frames", errs_before);

        // Stray words until the result pulse while out_data keeps the last result
        errs_before = err_cnt;
        held = last_result;
        for (int k = 0; k < frame_words; k++) begin
            frame[32*k +: 32] = next_rand();
        end
        send_frame(frame, 0);
        result_seen = 1'b0;
        while (!result_seen) begin
            @(posedge clk);
            r_valid <= 1'b1;
            in_data <= next_rand();
            @(negedge clk);
            if (t_valid) begin
                result_seen = 1'b1;
            end else begin
                check_value(out_data, held, "out_data during compute");
            end
        end
        @(posedge clk);
        r_valid <= 1'b0;
        wait_results();
        for (int k = 0; k < frame_words; k++) begin
            frame[32*k +: 32] = next_rand();
        end
        send_frame(frame, 2);
        wait_results();
        test_done("Test 5 words ignored during compute", errs_before);

        // Quiet period catches any late pulse
        repeat (20) @(negedge clk);
        check_value(result_word_t'(pulse_cnt), result_word_t'(frames_sent), "final t_valid count");

        $display("Frames %0d, checks %0d, errors %0d", frames_sent, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: logic/fc_top.sv
// Fully connected layer top, joins sequencer, frame RAM, operand registers and compute engine
`timescale 1ns/10ps

module fc_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       r_valid,
    input  fc_mem_pkg::word_t          in_data,
    output logic                       t_valid,
    output fc_layer_pkg::result_word_t out_data
);
    import fc_layer_pkg::*;
    import fc_mem_pkg::*;

    // RAM port
    logic         mem_en;
    logic         mem_we;
    mem_addr_t    mem_addr;
    word_t        mem_wdata;
    word_t        mem_rdata;

    // Operand loading and row handover
    logic         load_strobe;
    load_sel_t    load_sel;
    word_t        load_word;
    logic         row_ready;
    logic         row_take;
    logic         frame_done;

    // Operands seen by the engine
    feature_vec_t feature;
    bias_vec_t    bias;
    weight_row_t  row;

    fc_bram_sequencer i_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .r_valid     (r_valid),
        .in_data     (in_data),
        .mem_rdata   (mem_rdata),
        .row_take    (row_take),
        .frame_done  (frame_done),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .load_strobe (load_strobe),
        .load_sel    (load_sel),
        .load_word   (load_word),
        .row_ready   (row_ready)
    );

    fc_weight_ram i_ram (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    fc_operand_regs i_operands (
        .clk         (clk),
        .rstn        (rstn),
        .load_strobe (load_strobe),
        .load_sel    (load_sel),
        .load_word   (load_word),
        .row_take    (row_take),
        .feature     (feature),
        .bias        (bias),
        .row         (row)
    );

    fc_mac_engine i_engine (
        .clk        (clk),
        .rstn       (rstn),
        .row_ready  (row_ready),
        .feature    (feature),
        .bias       (bias),
        .row        (row),
        .row_take   (row_take),
        .frame_done (frame_done),
        .t_valid    (t_valid),
        .out_data   (out_data)
    );

endmodule

// File: logic/fc_mac_engine.sv
// Compute engine with per-output accumulate, bias add, saturating quantize and result packing
`timescale 1ns/10ps

module fc_mac_engine (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       row_ready,
    input  fc_layer_pkg::feature_vec_t feature,
    input  fc_layer_pkg::bias_vec_t    bias,
    input  fc_layer_pkg::weight_row_t  row,
    output logic                       row_take,
    output logic                       frame_done,
    output logic                       t_valid,
    output fc_layer_pkg::result_word_t out_data
);
    import fc_layer_pkg::*;

    typedef enum logic [1:0] {st_idle, st_accumulate, st_bias_add} state_t;

    state_t                        state;
    logic [$clog2(n_inputs)-1:0]   mac_idx;
    logic [$clog2(n_outputs)-1:0]  out_idx;
    acc_t                          acc;
    data_t                         x_byte;
    data_t                         w_byte;
    data_t                         b_byte;
    logic signed [2*byte_bits-1:0] product;
    acc_t                          biased;
    acc_t                          scaled;
    logic                          in_range;
    data_t                         result_q;
    // Finished bytes of the current frame, newest at the top
    logic [(n_outputs-1)*byte_bits-1:0] res_q;

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    // One product per cycle
    assign x_byte  = data_t'(feature[mac_idx*byte_bits +: byte_bits]);
    assign w_byte  = data_t'(row[mac_idx*byte_bits +: byte_bits]);
    assign product = x_byte * w_byte;

    // Bias sits at the weight scale, so align it at bit q_shift
    assign b_byte = data_t'(bias[out_idx*byte_bits +: byte_bits]);
    assign biased = acc + (acc_t'(b_byte) <<< q_shift);
    assign scaled = biased >>> q_shift;

    // Fits in int8 when all bits above the sign agree with it
    assign in_range = (&scaled[acc_bits-1:byte_bits-1]) || !(|scaled[acc_bits-1:byte_bits-1]);

    always_comb begin
        if (in_range) begin
            result_q = data_t'(scaled[byte_bits-1:0]);
        end else if (scaled[acc_bits-1]) begin
            result_q = {1'b1, {(byte_bits-1){1'b0}}};
        end else begin
            result_q = {1'b0, {(byte_bits-1){1'b1}}};
        end
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    // Row is copied into the active register in this same edge
    assign row_take   = (state == st_idle) && row_ready;
    // The sequencer leaves its frame on the result pulse
    assign frame_done = t_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            mac_idx  <= '0;
            out_idx  <= '0;
            acc      <= '0;
            res_q    <= '0;
            t_valid  <= 1'b0;
            out_data <= '0;
        end else begin
            t_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (row_ready) begin
                        acc     <= '0;
                        mac_idx <= '0;
                        state   <= st_accumulate;
                    end
                end
                st_accumulate: begin
                    // Partial sums stay at full width
                    acc     <= acc + acc_t'(product);
                    mac_idx <= mac_idx + 1'b1;
                    if (mac_idx == n_inputs - 1) begin
                        state <= st_bias_add;
                    end
                end
                st_bias_add: begin
                    // Each new byte enters at the top and older ones move down
                    res_q   <= {result_q, res_q[(n_outputs-1)*byte_bits-1:byte_bits]};
                    out_idx <= out_idx + 1'b1;
                    // Last output sends the whole word and closes the frame
                    // Counter wraps to zero here
                    if (out_idx == n_outputs - 1) begin
                        out_data <= {result_q, res_q};
                        t_valid  <= 1'b1;
                    end
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_tvalid_single: assert property (@(posedge clk) disable iff (!rstn)
        t_valid |=> !t_valid)
        else $error("t_valid held high for more than one cycle");

endmodule

// File: logic/fc_operand_regs.sv
// Operand registers for the compute engine, inputs, bias, row buffer and active row
`timescale 1ns/10ps

module fc_operand_regs (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       load_strobe,
    input  fc_mem_pkg::load_sel_t      load_sel,
    input  fc_mem_pkg::word_t          load_word,
    input  logic                       row_take,
    output fc_layer_pkg::feature_vec_t feature,
    output fc_layer_pkg::bias_vec_t    bias,
    output fc_layer_pkg::weight_row_t  row
);
    import fc_layer_pkg::*;
    import fc_mem_pkg::*;

    // Next row fills here while the engine works on the active one
    weight_row_t row_buf;

    // Words arrive low first, each one shifts the field right by a word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            feature <= '0;
            bias    <= '0;
            row_buf <= '0;
        end else if (load_strobe) begin
            case (load_sel)
                sel_input: begin
                    feature <= feature_vec_t'({load_word, feature} >> $bits(word_t));
                end
                sel_bias: begin
                    bias <= bias_vec_t'({load_word, bias} >> $bits(word_t));
                end
                sel_row: begin
                    row_buf <= weight_row_t'({load_word, row_buf} >> $bits(word_t));
                end
                default: begin
                    row_buf <= row_buf;
                end
            endcase
        end
    end

    // Engine takes a row in one edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row <= '0;
        end else if (row_take) begin
            row <= row_buf;
        end
    end

endmodule

// File: logic/fc_bram_sequencer.sv
// Frame receive into the RAM and operand fetch sequencing with weight row prefetch
`timescale 1ns/10ps

module fc_bram_sequencer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  r_valid,
    input  fc_mem_pkg::word_t     in_data,
    input  fc_mem_pkg::word_t     mem_rdata,
    input  logic                  row_take,
    input  logic                  frame_done,
    output logic                  mem_en,
    output logic                  mem_we,
    output fc_mem_pkg::mem_addr_t mem_addr,
    output fc_mem_pkg::word_t     mem_wdata,
    output logic                  load_strobe,
    output fc_mem_pkg::load_sel_t load_sel,
    output fc_mem_pkg::word_t     load_word,
    output logic                  row_ready
);
    import fc_layer_pkg::*;
    import fc_mem_pkg::*;

    typedef enum logic [2:0] {
        st_receive,
        st_fetch_input,
        st_fetch_bias,
        st_fetch_row,
        st_wait_take,
        st_wait_done
    } state_t;

    state_t                           state;
    logic [$clog2(frame_words)-1:0]   word_cnt;
    logic [$clog2(n_outputs)-1:0]     row_cnt;
    logic [2:0]                       burst_cnt;
    logic [2:0]                       burst_words;
    logic                             burst_end;
    mem_addr_t                        rx_addr;
    mem_addr_t                        rd_addr;
    load_sel_t                        rd_sel;
    logic [read_latency-1:0]          vld_pipe;
    load_sel_t                        sel_pipe [read_latency];

    ////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////

    // Received word index onto the three regions
    always_comb begin
        if (word_cnt < input_words) begin
            rx_addr = input_base + mem_addr_t'(word_cnt);
        end else if (word_cnt < input_words + weight_words) begin
            rx_addr = weight_base + mem_addr_t'(word_cnt - input_words);
        end else begin
            rx_addr = bias_base + mem_addr_t'(word_cnt - input_words - weight_words);
        end
    end

    // Burst length, read address and load target of the current fetch phase
    always_comb begin
        burst_words = '0;
        rd_addr     = input_base;
        rd_sel      = sel_none;
        case (state)
            st_fetch_input: begin
                burst_words = 3'(input_words);
                rd_addr     = input_base + mem_addr_t'(burst_cnt);
                rd_sel      = sel_input;
            end
            st_fetch_bias: begin
                burst_words = 3'(bias_words);
                rd_addr     = bias_base + mem_addr_t'(burst_cnt);
                rd_sel      = sel_bias;
            end
            st_fetch_row: begin
                burst_words = 3'(row_words);
                // Two words per output row
                rd_addr     = weight_base + mem_addr_t'(row_cnt * row_words + burst_cnt);
                rd_sel      = sel_row;
            end
            default: begin
                burst_words = '0;
            end
        endcase
    end

    // Last cycle of a burst, the final word is on mem_rdata here
    assign burst_end = (burst_words != '0)
                    && (burst_cnt == burst_words + 3'(read_latency - 1));

    // Writes follow r_valid directly, reads issue in the first burst cycles
    assign mem_we    = (state == st_receive) && r_valid;
    assign mem_en    = mem_we || (burst_cnt < burst_words);
    assign mem_addr  = (state == st_receive) ? rx_addr : rd_addr;
    assign mem_wdata = in_data;

    ////////////////////////////////////////
    // Read return pipe
    ////////////////////////////////////////

    // Issued reads delayed by the RAM latency become load strobes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_pipe <= '0;
            for (int i = 0; i < read_latency; i++) begin
                sel_pipe[i] <= sel_none;
            end
        end else begin
            vld_pipe[0] <= mem_en && !mem_we;
            sel_pipe[0] <= rd_sel;
            for (int i = 1; i < read_latency; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
                sel_pipe[i] <= sel_pipe[i-1];
            end
        end
    end

    assign load_strobe = vld_pipe[read_latency-1];
    assign load_sel    = sel_pipe[read_latency-1];
    assign load_word   = mem_rdata;

    ////////////////////////////////////////
    // Phase control
    ////////////////////////////////////////

    // Counts through each fetch burst, idle at zero otherwise
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            burst_cnt <= '0;
        end else if (burst_words == '0 || burst_end) begin
            burst_cnt <= '0;
        end else begin
            burst_cnt <= burst_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_receive;
            word_cnt  <= '0;
            row_cnt   <= '0;
            row_ready <= 1'b0;
        end else begin
            case (state)
                st_receive: begin
                    if (r_valid) begin
                        if (word_cnt == frame_words - 1) begin
                            word_cnt <= '0;
                            state    <= st_fetch_input;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                st_fetch_input: begin
                    if (burst_end) begin
                        state <= st_fetch_bias;
                    end
                end
                st_fetch_bias: begin
                    if (burst_end) begin
                        state <= st_fetch_row;
                    end
                end
                st_fetch_row: begin
                    // Row buffer complete after this edge
                    if (burst_end) begin
                        row_ready <= 1'b1;
                        state     <= st_wait_take;
                    end
                end
                st_wait_take: begin
                    if (row_take) begin
                        row_ready <= 1'b0;
                        if (row_cnt == n_outputs - 1) begin
                            row_cnt <= '0;
                            state   <= st_wait_done;
                        end else begin
                            // Prefetch the next row under the running accumulation
                            row_cnt <= row_cnt + 1'b1;
                            state   <= st_fetch_row;
                        end
                    end
                end
                st_wait_done: begin
                    if (frame_done) begin
                        state <= st_receive;
                    end
                end
                default: begin
                    state <= st_receive;
                end
            endcase
        end
    end

    a_take_needs_ready: assert property (@(posedge clk) disable iff (!rstn)
        row_take |-> row_ready)
        else $error("row_take raised while no weight row was ready");

endmodule

// File: logic/fc_weight_ram.sv
// Frame storage RAM, 16 x 32 single port with registered address and registered output
`timescale 1ns/10ps

module fc_weight_ram (
    input  logic                  clk,
    input  logic                  mem_en,
    input  logic                  mem_we,
    input  fc_mem_pkg::mem_addr_t mem_addr,
    input  fc_mem_pkg::word_t     mem_wdata,
    output fc_mem_pkg::word_t     mem_rdata
);
    import fc_mem_pkg::*;

    word_t     mem [mem_depth];
    mem_addr_t addr_q;
    logic      in_map;

    // Write lands in this edge, a read only captures its address
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                addr_q <= mem_addr;
            end
        end
    end

    // Second read stage
    always_ff @(posedge clk) begin
        mem_rdata <= mem[addr_q];
    end

    // Address falls in the input, weight or bias region
    // Unsigned wrap makes addresses below a base fail the compare
    assign in_map = (mem_addr - input_base < input_words)
                 || (mem_addr - weight_base < weight_words)
                 || (mem_addr - bias_base < bias_words);

    a_write_in_map: assert property (@(posedge clk) mem_en && mem_we |-> in_map)
        else $error("RAM write to unmapped address %0d", mem_addr);

endmodule

// File: logic/fc_mem_pkg.sv
// Frame memory map, word counts, read latency and operand load targets
package fc_mem_pkg;

    typedef logic [31:0] word_t;

    localparam int mem_depth = 16;
    typedef logic [$clog2(mem_depth)-1:0] mem_addr_t;

    // Region base addresses
    localparam mem_addr_t input_base  = 4'd0;
    localparam mem_addr_t weight_base = 4'd4;
    localparam mem_addr_t bias_base   = 4'd14;

    // Region sizes in words
    localparam int input_words  = 2;
    localparam int row_words    = 2;
    localparam int weight_words = 8;
    localparam int bias_words   = 1;
    localparam int frame_words  = input_words + weight_words + bias_words;

    // Cycles from read request to data on the port
    localparam int read_latency = 2;

    // Operand register that a fetched word is shifted into
    typedef enum logic [1:0] {sel_none, sel_input, sel_bias, sel_row} load_sel_t;

endpackage

// File: logic/fc_layer_pkg.sv
// Fully connected layer geometry, arithmetic widths and packed operand vector types
package fc_layer_pkg;

    ////////////////////////////////////////
    // Layer geometry
    ////////////////////////////////////////

    localparam int byte_bits = 8;
    localparam int n_inputs  = 8;
    localparam int n_outputs = 4;

    ////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////

    // Full width sum of 8 int8 products plus the shifted bias
    localparam int acc_bits = 20;
    // Fixed point alignment of weights and bias
    localparam int q_shift  = 8;

    typedef logic signed [byte_bits-1:0] data_t;
    typedef logic signed [acc_bits-1:0]  acc_t;

    // Packed vectors, element i sits at bit byte_bits*i
    typedef logic [n_inputs*byte_bits-1:0]  feature_vec_t;
    typedef logic [n_inputs*byte_bits-1:0]  weight_row_t;
    typedef logic [n_outputs*byte_bits-1:0] bias_vec_t;
    typedef logic [n_outputs*byte_bits-1:0] result_word_t;

endpackage
